// File: include/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

// architectural integer registers
`define RV_NREGS 32

`endif

// File: hw/rv_pkg.sv
package rv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_lui    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    // operand source picked by the hazard unit
    typedef enum logic [1:0] {
        fwd_none,
        fwd_from_mem,
        fwd_from_wb
    } fwd_sel_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        alu_op_e     alu_op;
        logic        alu_src;
        logic        branch;
        logic        bne;
        logic        jal;
        logic        mem_ren;
        logic        mem_wen;
        logic        reg_wen;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [4:0]  rd;
        logic [31:0] pc_step;
        logic        mem_ren;
        logic        mem_wen;
        logic        reg_wen;
        logic        jump;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] alu_result;
        logic [31:0] mem_data;
        logic [31:0] pc_step;
        logic [4:0]  rd;
        logic        mem_to_reg;
        logic        reg_wen;
        logic        jump;
    } mem_wb_t;

endpackage

// File: hw/rv_fetch.sv
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_fetch (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           hold,
    input  logic           redirect,
    input  logic [31:0]    target,
    input  logic           flush,
    input  logic           icache_stall,
    input  logic [31:0]    icache_rdata,
    output logic           icache_ren,
    output logic [29:0]    icache_addr,
    output logic [31:0]    pc,
    output rv_pkg::if_id_t if_id
);

    // fetch never pauses its request, a held pc simply refetches
    assign icache_ren  = 1'b1;
    assign icache_addr = pc[31:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc    <= `RV_RESET_PC;
            if_id <= '{valid: 1'b0, pc: '0, inst: `RV_NOP};
        end else if (!hold) begin
            // redirect from EX wins over sequential fetch
            if (redirect) begin
                pc <= target;
            end else if (!icache_stall) begin
                pc <= pc + 32'd4;
            end
            if (flush || icache_stall) begin
                if_id <= '{valid: 1'b0, pc: pc, inst: `RV_NOP};
            end else begin
                if_id <= '{valid: 1'b1, pc: pc, inst: icache_rdata};
            end
        end
    end

    // branch and jal targets come out of EX
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

// File: hw/rv_decode.sv
`timescale 1ns/100ps

module rv_decode (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           hold,
    input  logic           flush,
    input  logic           bubble,
    input  rv_pkg::if_id_t if_id,
    input  logic [31:0]    rs1_data,
    input  logic [31:0]    rs2_data,
    output logic [4:0]     rs1,
    output logic [4:0]     rs2,
    output rv_pkg::id_ex_t id_ex
);

    logic [31:0]     inst;
    logic [2:0]      funct3;
    rv_pkg::opcode_e opc;
    rv_pkg::id_ex_t  dec;

    assign inst   = if_id.inst;
    assign funct3 = inst[14:12];
    assign opc    = rv_pkg::opcode_e'(inst[6:0]);
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        dec          = '0;
        dec.valid    = if_id.valid;
        dec.pc       = if_id.pc;
        dec.rs1      = rs1;
        dec.rs2      = rs2;
        dec.rd       = inst[11:7];
        dec.rs1_data = rs1_data;
        dec.rs2_data = rs2_data;
        dec.alu_op   = rv_pkg::alu_add;
        case (opc)
            rv_pkg::opc_op: begin
                dec.reg_wen = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = inst[30] ? rv_pkg::alu_sub : rv_pkg::alu_add;
                    3'b010:  dec.alu_op = rv_pkg::alu_slt;
                    3'b100:  dec.alu_op = rv_pkg::alu_xor;
                    3'b110:  dec.alu_op = rv_pkg::alu_or;
                    3'b111:  dec.alu_op = rv_pkg::alu_and;
                    default: dec.reg_wen = 1'b0;
                endcase
            end
            rv_pkg::opc_op_imm: begin
                // addi only
                dec.alu_src = 1'b1;
                dec.imm     = {{20{inst[31]}}, inst[31:20]};
                dec.reg_wen = (funct3 == 3'b000);
            end
            rv_pkg::opc_load: begin
                dec.alu_src = 1'b1;
                dec.imm     = {{20{inst[31]}}, inst[31:20]};
                dec.mem_ren = 1'b1;
                dec.reg_wen = 1'b1;
            end
            rv_pkg::opc_store: begin
                dec.alu_src = 1'b1;
                dec.imm     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                dec.mem_wen = 1'b1;
            end
            rv_pkg::opc_branch: begin
                dec.imm    = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                dec.branch = 1'b1;
                dec.bne    = funct3[0];
            end
            rv_pkg::opc_jal: begin
                dec.imm     = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                dec.jal     = 1'b1;
                dec.reg_wen = 1'b1;
            end
            rv_pkg::opc_lui: begin
                dec.alu_src = 1'b1;
                dec.alu_op  = rv_pkg::alu_pass_b;
                dec.imm     = {inst[31:12], 12'b0};
                dec.reg_wen = 1'b1;
            end
            // anything else passes as a nop
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!hold) begin
            id_ex <= dec;
            if (flush || bubble) begin
                id_ex.valid <= 1'b0;
            end
        end
    end

endmodule

// File: hw/rv_regfile.sv
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        wen,
    input  logic [31:0] wdata,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    // x0 has no storage
    logic [31:0] regs [1:`RV_NREGS-1];

    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        // same-cycle writeback passes straight through
        if (wen && rd == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    assign rs1_data = read_port(rs1);
    assign rs2_data = read_port(rs2);

    always_ff @(posedge clk) begin
        if (rst_n && wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

endmodule

// File: hw/rv_hazard_unit.sv
`timescale 1ns/100ps

module rv_hazard_unit (
    input  logic              [4:0] id_rs1,
    input  logic              [4:0] id_rs2,
    input  rv_pkg::id_ex_t          id_ex,
    input  rv_pkg::ex_mem_t         ex_mem,
    input  rv_pkg::mem_wb_t         mem_wb,
    output logic                    load_use,
    output rv_pkg::fwd_sel_e        fwd_a,
    output rv_pkg::fwd_sel_e        fwd_b
);

    // MEM is younger than WB and wins
    function automatic rv_pkg::fwd_sel_e fwd_pick(input logic [4:0] rs);
        if (ex_mem.valid && ex_mem.reg_wen && ex_mem.rd != 5'd0 && ex_mem.rd == rs) begin
            return rv_pkg::fwd_from_mem;
        end
        if (mem_wb.valid && mem_wb.reg_wen && mem_wb.rd != 5'd0 && mem_wb.rd == rs) begin
            return rv_pkg::fwd_from_wb;
        end
        return rv_pkg::fwd_none;
    endfunction

    assign fwd_a = fwd_pick(id_ex.rs1);
    assign fwd_b = fwd_pick(id_ex.rs2);

    // load in EX feeding the instruction in decode
    assign load_use = id_ex.valid && id_ex.mem_ren && id_ex.rd != 5'd0 &&
                      (id_ex.rd == id_rs1 || id_ex.rd == id_rs2);

endmodule

// File: hw/rv_execute.sv
`timescale 1ns/100ps

module rv_execute (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             hold,
    input  rv_pkg::id_ex_t   id_ex,
    input  rv_pkg::fwd_sel_e fwd_a,
    input  rv_pkg::fwd_sel_e fwd_b,
    input  logic [31:0]      mem_fwd_data,
    input  logic [31:0]      wb_fwd_data,
    output logic             redirect,
    output logic [31:0]      target,
    output rv_pkg::ex_mem_t  ex_mem
);

    logic [31:0] op_a, op_b, alu_b, alu_result;
    logic [31:0] held_a, held_b;
    logic        held;
    logic        taken;

    always_comb begin
        case (fwd_a)
            rv_pkg::fwd_from_mem: op_a = mem_fwd_data;
            rv_pkg::fwd_from_wb:  op_a = wb_fwd_data;
            default:              op_a = id_ex.rs1_data;
        endcase
        case (fwd_b)
            rv_pkg::fwd_from_mem: op_b = mem_fwd_data;
            rv_pkg::fwd_from_wb:  op_b = wb_fwd_data;
            default:              op_b = id_ex.rs2_data;
        endcase
        // a WB producer drains during a dcache stall, so reuse the operands seen then
        if (held) begin
            op_a = held_a;
            op_b = held_b;
        end
    end

    assign alu_b = id_ex.alu_src ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            rv_pkg::alu_sub:    alu_result = op_a - alu_b;
            rv_pkg::alu_and:    alu_result = op_a & alu_b;
            rv_pkg::alu_or:     alu_result = op_a | alu_b;
            rv_pkg::alu_xor:    alu_result = op_a ^ alu_b;
            rv_pkg::alu_slt:    alu_result = {31'd0, $signed(op_a) < $signed(alu_b)};
            rv_pkg::alu_pass_b: alu_result = alu_b;
            default:            alu_result = op_a + alu_b;
        endcase
    end

    // beq and bne share the compare, bne inverts it
    assign taken    = id_ex.branch && ((op_a == op_b) ^ id_ex.bne);
    assign redirect = id_ex.valid && (taken || id_ex.jal);
    assign target   = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held <= 1'b0;
        end else begin
            held <= hold;
        end
    end

    always_ff @(posedge clk) begin
        if (hold) begin
            held_a <= op_a;
            held_b <= op_b;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!hold) begin
            ex_mem <= '{valid:      id_ex.valid,
                        alu_result: alu_result,
                        store_data: op_b,
                        rd:         id_ex.rd,
                        pc_step:    id_ex.pc + 32'd4,
                        mem_ren:    id_ex.mem_ren,
                        mem_wen:    id_ex.mem_wen,
                        reg_wen:    id_ex.reg_wen,
                        jump:       id_ex.jal};
        end
    end

endmodule

// File: hw/rv_memory.sv
`timescale 1ns/100ps

module rv_memory (
    input  logic            clk,
    input  logic            rst_n,
    input  rv_pkg::ex_mem_t ex_mem,
    input  logic            dcache_stall,
    input  logic [31:0]     dcache_rdata,
    output logic            dcache_ren,
    output logic            dcache_wen,
    output logic [29:0]     dcache_addr,
    output logic [31:0]     dcache_wdata,
    output rv_pkg::mem_wb_t mem_wb
);

    logic waiting;

    assign dcache_ren   = ex_mem.valid && ex_mem.mem_ren;
    assign dcache_wen   = ex_mem.valid && ex_mem.mem_wen;
    assign dcache_addr  = ex_mem.alu_result[31:2];
    assign dcache_wdata = ex_mem.store_data;

    // access not yet answered, WB sees a bubble
    assign waiting = dcache_stall && (dcache_ren || dcache_wen);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{valid:      ex_mem.valid && !waiting,
                        alu_result: ex_mem.alu_result,
                        mem_data:   dcache_rdata,
                        pc_step:    ex_mem.pc_step,
                        rd:         ex_mem.rd,
                        mem_to_reg: ex_mem.mem_ren,
                        reg_wen:    ex_mem.reg_wen,
                        jump:       ex_mem.jump};
        end
    end

    a_ren_wen_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcache_ren && dcache_wen));

    // the pipeline hold must freeze the request until the cache answers
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        waiting |=> $stable(dcache_addr) && $stable(dcache_ren) && $stable(dcache_wen));

endmodule

// File: hw/rv_pipeline.sv
`timescale 1ns/100ps

module rv_pipeline (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        icache_stall,
    output logic        icache_ren,
    output logic [29:0] icache_addr,
    input  logic [31:0] icache_rdata,
    input  logic        dcache_stall,
    output logic        dcache_ren,
    output logic        dcache_wen,
    output logic [29:0] dcache_addr,
    output logic [31:0] dcache_wdata,
    input  logic [31:0] dcache_rdata,
    output logic [31:0] pc
);

    rv_pkg::if_id_t   if_id;
    rv_pkg::id_ex_t   id_ex;
    rv_pkg::ex_mem_t  ex_mem;
    rv_pkg::mem_wb_t  mem_wb;
    rv_pkg::fwd_sel_e fwd_a, fwd_b;
    logic [4:0]       id_rs1, id_rs2;
    logic [31:0]      rs1_data, rs2_data;
    logic [31:0]      target, mem_fwd_data, wb_data;
    logic             redirect, load_use, hold, rf_wen;

    // memory op in MEM waiting on the data cache freezes everything
    assign hold = dcache_stall && ex_mem.valid && (ex_mem.mem_ren || ex_mem.mem_wen);

    assign mem_fwd_data = ex_mem.jump ? ex_mem.pc_step : ex_mem.alu_result;

    // writeback select
    assign wb_data = mem_wb.mem_to_reg ? mem_wb.mem_data :
                     mem_wb.jump       ? mem_wb.pc_step  : mem_wb.alu_result;
    assign rf_wen  = mem_wb.valid && mem_wb.reg_wen;

    rv_fetch rv_fetch_i (
        .clk(clk), .rst_n(rst_n), .hold(hold || load_use), .redirect(redirect),
        .target(target), .flush(redirect), .icache_stall(icache_stall),
        .icache_rdata(icache_rdata), .icache_ren(icache_ren), .icache_addr(icache_addr),
        .pc(pc), .if_id(if_id)
    );

    rv_decode rv_decode_i (
        .clk(clk), .rst_n(rst_n), .hold(hold), .flush(redirect), .bubble(load_use),
        .if_id(if_id), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1(id_rs1), .rs2(id_rs2), .id_ex(id_ex)
    );

    rv_regfile rv_regfile_i (
        .clk(clk), .rst_n(rst_n), .rs1(id_rs1), .rs2(id_rs2), .rd(mem_wb.rd),
        .wen(rf_wen), .wdata(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    rv_hazard_unit rv_hazard_unit_i (
        .id_rs1(id_rs1), .id_rs2(id_rs2), .id_ex(id_ex), .ex_mem(ex_mem),
        .mem_wb(mem_wb), .load_use(load_use), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    rv_execute rv_execute_i (
        .clk(clk), .rst_n(rst_n), .hold(hold), .id_ex(id_ex), .fwd_a(fwd_a),
        .fwd_b(fwd_b), .mem_fwd_data(mem_fwd_data), .wb_fwd_data(wb_data),
        .redirect(redirect), .target(target), .ex_mem(ex_mem)
    );

    rv_memory rv_memory_i (
        .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .dcache_stall(dcache_stall),
        .dcache_rdata(dcache_rdata), .dcache_ren(dcache_ren), .dcache_wen(dcache_wen),
        .dcache_addr(dcache_addr), .dcache_wdata(dcache_wdata), .mem_wb(mem_wb)
    );

endmodule

// File: sim/tb_rv_pipeline.sv
`timescale 1ns/100ps
`include "rv_defines.svh"

module tb_rv_pipeline;

    // major opcodes as the ISA defines them
    localparam logic [6:0] opc_reg    = 7'b0110011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    localparam logic [31:0] reset_pc        = `RV_RESET_PC;
    localparam int          cycles_per_inst = 40 * 4;
    localparam int          n_programs      = 4;

    logic        clk;
    logic        rst_n        = 1'b0;
    logic        icache_stall = 1'b0;
    logic        icache_ren;
    logic [29:0] icache_addr;
    logic [31:0] icache_rdata = `RV_NOP;
    logic        dcache_stall = 1'b0;
    logic        dcache_ren;
    logic        dcache_wen;
    logic [29:0] dcache_addr;
    logic [31:0] dcache_wdata;
    logic [31:0] dcache_rdata = 32'd0;
    logic [31:0] pc;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [29:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [29:0] cap_addr [$];
    logic [31:0] cap_data [$];
    logic [29:0] seen_addr;
    logic [31:0] seen_data;
    integer      seed         = 32'h0d31_b408;
    bit          stall_on     = 1'b0;
    int          prog_len     = 0;
    int          got_cnt      = 0;
    int          store_errors = 0;
    int          test_errors  = 0;
    int          failed_tests = 0;
    int          budget       = 0;

    rv_pipeline rv_pipeline_i (
        .clk(clk), .rst_n(rst_n),
        .icache_stall(icache_stall), .icache_ren(icache_ren),
        .icache_addr(icache_addr), .icache_rdata(icache_rdata),
        .dcache_stall(dcache_stall), .dcache_ren(dcache_ren), .dcache_wen(dcache_wen),
        .dcache_addr(dcache_addr), .dcache_wdata(dcache_wdata),
        .dcache_rdata(dcache_rdata), .pc(pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] fill_word(input int idx);
        return 32'hc3a5_1e00 ^ (idx * 32'h0104_0917);
    endfunction

    function automatic logic [31:0] alu_ins(input int f7, input int f3, input int rd,
                                            input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc_reg};
    endfunction

    function automatic logic [31:0] addi_ins(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], opc_imm};
    endfunction

    function automatic logic [31:0] lw_ins(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], opc_load};
    endfunction

    function automatic logic [31:0] sw_ins(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] br_ins(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                opc_branch};
    endfunction

    function automatic logic [31:0] jal_ins(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opc_jal};
    endfunction

    function automatic logic [31:0] lui_ins(input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc_lui};
    endfunction

    function automatic string test_name(input int id);
        case (id)
            0:       return "alu_forwarding";
            1:       return "load_use";
            2:       return "branch_jal";
            default: return "x0_write";
        endcase
    endfunction

    task automatic put(input logic [31:0] ins);
        imem[prog_len] = ins;
        prog_len++;
    endtask

    task automatic load_program(input int id);
        for (int i = 0; i < 256; i++) begin
            imem[i] = addi_ins(0, 0, i);
        end
        prog_len = 0;
        case (id)
            0: begin
                put(addi_ins(20, 0, 64));
                put(addi_ins(1, 0, 5));
                put(addi_ins(2, 1, 7));
                put(sw_ins(2, 20, 0));
                put(alu_ins(0, 0, 3, 1, 2));
                put(sw_ins(3, 20, 4));
                put(alu_ins(32, 0, 4, 1, 3));
                put(sw_ins(4, 20, 8));
                put(alu_ins(0, 4, 5, 4, 2));
                put(alu_ins(0, 6, 6, 5, 3));
                put(alu_ins(0, 7, 7, 6, 4));
                put(sw_ins(7, 20, 12));
                put(alu_ins(0, 2, 8, 4, 1));
                put(alu_ins(0, 2, 9, 1, 4));
                put(sw_ins(8, 20, 16));
                put(sw_ins(9, 20, 20));
                put(lui_ins(10, 20'habcde));
                put(addi_ins(10, 10, -1));
                put(sw_ins(10, 20, 24));
                put(sw_ins(6, 20, 28));
            end
            1: begin
                put(addi_ins(20, 0, 128));
                put(lw_ins(1, 20, 0));
                put(addi_ins(2, 1, 1));
                put(sw_ins(2, 20, 0));
                put(lw_ins(3, 20, 4));
                put(sw_ins(3, 20, 8));
                put(lw_ins(4, 20, 0));
                put(alu_ins(0, 0, 5, 4, 4));
                put(sw_ins(5, 20, 12));
                put(lw_ins(6, 20, 12));
                put(lw_ins(7, 20, 8));
                put(alu_ins(32, 0, 8, 6, 7));
                put(sw_ins(8, 20, 16));
            end
            2: begin
                put(addi_ins(1, 0, 3));
                put(addi_ins(2, 0, 3));
                put(addi_ins(20, 0, 200));
                put(addi_ins(3, 0, 7));
                put(addi_ins(4, 0, 8));
                // taken beq skips two writes
                put(br_ins(0, 1, 2, 12));
                put(addi_ins(3, 0, 111));
                put(addi_ins(4, 0, 222));
                put(addi_ins(5, 0, 1));
                put(br_ins(1, 1, 2, 8));
                put(addi_ins(6, 0, 2));
                put(br_ins(0, 1, 5, 8));
                put(addi_ins(7, 0, 4));
                // bne taken
                put(br_ins(1, 1, 5, 12));
                put(addi_ins(6, 0, 99));
                put(addi_ins(7, 0, 98));
                put(jal_ins(8, 12));
                put(addi_ins(5, 0, 77));
                put(addi_ins(5, 0, 76));
                // backward branch loop of three passes
                put(addi_ins(9, 0, 3));
                put(addi_ins(10, 0, 0));
                put(addi_ins(10, 10, 5));
                put(addi_ins(9, 9, -1));
                put(br_ins(1, 9, 0, -8));
                put(sw_ins(3, 20, 0));
                put(sw_ins(4, 20, 4));
                put(sw_ins(5, 20, 8));
                put(sw_ins(6, 20, 12));
                put(sw_ins(7, 20, 16));
                put(sw_ins(8, 20, 20));
                put(sw_ins(10, 20, 24));
            end
            default: begin
                put(addi_ins(20, 0, 32));
                put(addi_ins(0, 0, 55));
                put(sw_ins(0, 20, 0));
                put(lui_ins(0, 20'h12345));
                put(alu_ins(0, 0, 1, 0, 0));
                put(sw_ins(1, 20, 4));
                put(lw_ins(0, 20, 12));
                put(sw_ins(0, 20, 8));
            end
        endcase
        // every program parks in a self-loop
        put(jal_ins(0, 0));
    endtask

    // ISA model that collects the stores in program order
    function automatic void ref_run();
        logic [31:0] regs [32];
        logic [31:0] mem [256];
        logic [31:0] ref_pc, next_pc, ins, a, b, res, ea;
        logic [31:0] imm_i, imm_s, imm_b, imm_j;
        logic        wr;
        bit          done;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        exp_addr.delete();
        exp_data.delete();
        ref_pc = reset_pc;
        done   = 1'b0;
        steps  = 0;
        while (!done && steps < 4096) begin
            ins     = imem[ref_pc[9:2]];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            wr      = 1'b0;
            res     = 32'd0;
            next_pc = ref_pc + 32'd4;
            case (ins[6:0])
                opc_reg: begin
                    wr = 1'b1;
                    case (ins[14:12])
                        3'b000:  res = ins[30] ? a - b : a + b;
                        3'b010:  res = {31'd0, $signed(a) < $signed(b)};
                        3'b100:  res = a ^ b;
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                end
                opc_imm: begin
                    wr  = 1'b1;
                    res = a + imm_i;
                end
                opc_load: begin
                    wr  = 1'b1;
                    ea  = a + imm_i;
                    res = mem[ea[9:2]];
                end
                opc_store: begin
                    ea = a + imm_s;
                    mem[ea[9:2]] = b;
                    exp_addr.push_back(ea[31:2]);
                    exp_data.push_back(b);
                end
                opc_branch: begin
                    if ((a == b) != ins[12]) begin
                        next_pc = ref_pc + imm_b;
                    end
                end
                opc_jal: begin
                    wr      = 1'b1;
                    res     = ref_pc + 32'd4;
                    next_pc = ref_pc + imm_j;
                end
                opc_lui: begin
                    wr  = 1'b1;
                    res = {ins[31:12], 12'd0};
                end
                default: ;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = res;
            end
            done    = (next_pc == ref_pc);
            ref_pc  = next_pc;
            steps++;
        end
    endfunction

    // cache models answer the request that is stable in this cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] = fill_word(i);
            end
        end
        icache_stall = stall_on && (($random(seed) & 3) == 0);
        icache_rdata = imem[icache_addr[7:0]];
        dcache_stall = stall_on && (dcache_ren || dcache_wen) && (($random(seed) & 3) == 0);
        dcache_rdata = dmem[dcache_addr[7:0]];
        if (dcache_wen && !dcache_stall) begin
            dmem[dcache_addr[7:0]] = dcache_wdata;
            cap_addr.push_back(dcache_addr);
            cap_data.push_back(dcache_wdata);
        end
    end

    // compare each accepted store with the next one from the model
    always @(posedge clk) begin
        if (!rst_n) begin
            got_cnt = 0;
        end else if (cap_addr.size() > 0) begin
            seen_addr = cap_addr.pop_front();
            seen_data = cap_data.pop_front();
            if (got_cnt >= int'(exp_addr.size())) begin
                $display("unexpected store to word %h with data %h at %0t",
                         seen_addr, seen_data, $time);
                store_errors++;
            end else begin
                if (seen_addr !== exp_addr[got_cnt]) begin
                    $display("ERR %0t dcache_addr got %h expected %h",
                             $time, seen_addr, exp_addr[got_cnt]);
                    store_errors++;
                end
                if (seen_data !== exp_data[got_cnt]) begin
                    $display("ERR %0t dcache_wdata got %h expected %h",
                             $time, seen_data, exp_data[got_cnt]);
                    store_errors++;
                end
            end
            got_cnt++;
        end
    end

    task automatic check_reset_state();
        if (dcache_ren !== 1'b0) begin
            $display("ERR %0t dcache_ren got %b expected 0", $time, dcache_ren);
            test_errors++;
        end
        if (dcache_wen !== 1'b0) begin
            $display("ERR %0t dcache_wen got %b expected 0", $time, dcache_wen);
            test_errors++;
        end
        if (icache_ren !== 1'b1) begin
            $display("ERR %0t icache_ren got %b expected 1", $time, icache_ren);
            test_errors++;
        end
        if (icache_addr !== reset_pc[31:2]) begin
            $display("ERR %0t icache_addr got %h expected %h",
                     $time, icache_addr, reset_pc[31:2]);
            test_errors++;
        end
        if (pc !== reset_pc) begin
            $display("ERR %0t pc got %h expected %h", $time, pc, reset_pc);
            test_errors++;
        end
    endtask

    task automatic run_test(input int id, input bit stalls);
        int limit;
        int exp_cnt;
        int cyc;
        int errs_before;
        @(negedge clk);
        rst_n       = 1'b0;
        stall_on    = stalls;
        errs_before = store_errors + test_errors;
        load_program(id);
        ref_run();
        exp_cnt = exp_addr.size();
        limit   = prog_len * cycles_per_inst;
        repeat (10) @(negedge clk);
        check_reset_state();
        rst_n = 1'b1;
        cyc   = 0;
        while (got_cnt < exp_cnt && cyc < limit) begin
            @(negedge clk);
            cyc++;
        end
        if (got_cnt < exp_cnt) begin
            $display("test %0d: missing store, only %0d of %0d stores arrived in %0d cycles",
                     id, got_cnt, exp_cnt, cyc);
            test_errors++;
        end else begin
            // quiet period to catch stray stores
            repeat (16) @(negedge clk);
        end
        if (store_errors + test_errors == errs_before) begin
            $display("test %0d %s stalls %0d: ok, %0d stores", id, test_name(id), stalls,
                     exp_cnt);
        end else begin
            failed_tests++;
            $display("test %0d %s stalls %0d: FAILED, %0d errors", id, test_name(id), stalls,
                     store_errors + test_errors - errs_before);
        end
    endtask

    initial begin
        int total;
        total = 0;
        for (int id = 0; id < n_programs; id++) begin
            load_program(id);
            total += 2 * (prog_len * cycles_per_inst + 40);
        end
        budget = total;
        for (int pass = 0; pass < 2; pass++) begin
            for (int id = 0; id < n_programs; id++) begin
                run_test(id, pass[0]);
            end
        end
        $display("%0d tests, %0d failed, %0d errors", 2 * n_programs, failed_tests,
                 store_errors + test_errors);
        if (failed_tests == 0 && store_errors + test_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        $display("watchdog expired after %0d cycles, a test never finished", budget);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: project.f
+incdir+include
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_hazard_unit.sv
hw/rv_execute.sv
hw/rv_memory.sv
hw/rv_pipeline.sv
sim/tb_rv_pipeline.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -j 0 -f project.f \
    --top-module tb_rv_pipeline -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Regression passed" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }
